/* files.f */
+incdir+rtl
+incdir+sim
rtl/bus_pkg.sv
rtl/debug_pkg.sv
rtl/bus_decoder.sv
rtl/byte_sram.sv
rtl/debug_regs.sv
rtl/soc_harness.sv
sim/tb_soc_harness.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_soc_harness -f files.f -o vsim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/vsim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* sim/tb_bus_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone and DMI driver tasks that live inside the testbench.
// Every task is entered and left on a falling clock edge.
// Uses the testbench signals and must follow their declaration.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Waits for ack or err and checks latency and response kind
task automatic wait_response(
    input logic [`BUS_ADDR_WIDTH-1:0] adr,
    input logic                       expect_err
);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > BUS_TIMEOUT) begin
            abort_run($sformatf("Timeout, no ack or err for address 0x%h", adr));
        end
    end while (!(wb_resp.ack || wb_resp.err));
    expect_equal("wb_resp latency", 64'h1, 64'(cycles));
    expect_equal("wb_resp.err", 64'(expect_err), 64'(wb_resp.err));
    expect_equal("wb_resp.ack", 64'(!expect_err), 64'(wb_resp.ack));
endtask

// One Wishbone classic transfer
task automatic bus_transfer(
    input  logic                       we,
    input  logic [`BUS_ADDR_WIDTH-1:0] adr,
    input  logic [`BUS_SEL_WIDTH-1:0]  sel,
    input  logic [`BUS_DATA_WIDTH-1:0] dat,
    input  logic                       expect_err,
    output logic [`BUS_DATA_WIDTH-1:0] rdata
);
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.sel = sel;
    wb_req.dat = dat;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wait_response(adr, expect_err);
    rdata      = wb_resp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    @(negedge clk);   // stb low for a cycle
endtask

// Read that keeps stb high for hold cycles after the response
task automatic held_stb_read(
    input  logic [`BUS_ADDR_WIDTH-1:0] adr,
    input  logic                       expect_err,
    input  int                         hold,
    output logic [`BUS_DATA_WIDTH-1:0] rdata
);
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.sel = '1;
    wb_req.dat = '0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wait_response(adr, expect_err);
    rdata = wb_resp.dat;
    repeat (hold) begin
        @(negedge clk);
        expect_equal("wb_resp.ack", 64'h0, 64'(wb_resp.ack));
        expect_equal("wb_resp.err", 64'h0, 64'(wb_resp.err));
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    @(negedge clk);
endtask

task automatic dmi_write(
    input logic [`DMI_ADDR_WIDTH-1:0] addr,
    input logic [`DMI_DATA_WIDTH-1:0] data
);
    dmi_req   = 1'b1;
    dmi_wr    = 1'b1;
    dmi_addr  = addr;
    dmi_wdata = data;
    @(negedge clk);
    dmi_req   = 1'b0;
    dmi_wr    = 1'b0;
endtask

// Read result is due one cycle after the strobe
task automatic dmi_read_check(
    input logic [`DMI_ADDR_WIDTH-1:0] addr,
    input logic [`DMI_DATA_WIDTH-1:0] expected
);
    int cycles;
    dmi_req   = 1'b1;
    dmi_wr    = 1'b0;
    dmi_addr  = addr;
    dmi_wdata = '0;
    cycles    = 0;
    do begin
        @(negedge clk);
        dmi_req = 1'b0;
        cycles++;
        if (cycles > DMI_TIMEOUT) begin
            abort_run($sformatf("Timeout, dmi_rdata_o never became 0x%h, last 0x%h",
                                expected, dmi_rdata));
        end
    end while (dmi_rdata !== expected);
    expect_equal("dmi_rdata_o latency", 64'h1, 64'(cycles));
endtask

`endif

/* sim/tb_soc_harness.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory and debug harness.
// SRAM reads are only compared on words that were fully written
// first, since SRAM content is undefined after reset.
// Stops at the first failing check.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "harness_macros.svh"

module tb_soc_harness import bus_pkg::*, debug_pkg::*; ();

    localparam int unsigned SEED        = 32'h1453_0483;
    localparam int          BUS_TIMEOUT = 16;
    localparam int          DMI_TIMEOUT = 16;
    localparam int          NUM_WORDS   = 16;
    localparam int          NUM_PARTIAL = 48;
    localparam int          IDX_BITS    = $clog2(`SRAM_WORDS);

    logic                       clk;
    logic                       rst_n;
    wb_req_t                    wb_req;
    wb_resp_t                   wb_resp;
    logic                       dmi_req;
    logic                       dmi_wr;
    logic [`DMI_ADDR_WIDTH-1:0] dmi_addr;
    logic [`DMI_DATA_WIDTH-1:0] dmi_wdata;
    logic [`DMI_DATA_WIDTH-1:0] dmi_rdata;
    logic                       debug_req;

    logic [`BUS_DATA_WIDTH-1:0] model_mem [`SRAM_WORDS];   // Reference SRAM
    logic [IDX_BITS-1:0]        word_idx [NUM_WORDS];

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  sel);
        logic [63:0] mask;
        for (int b = 0; b < 8; b++) begin
            mask[b*8 +: 8] = {8{sel[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [`BUS_ADDR_WIDTH-1:0] word_addr(input logic [IDX_BITS-1:0] idx);
        return `ROM_BASE + (32'(idx) << 3);
    endfunction

    `include "tb_bus_tasks.svh"

    soc_harness i_soc_harness (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .wb_req_i    ( wb_req    ),
        .wb_resp_o   ( wb_resp   ),
        .dmi_req_i   ( dmi_req   ),
        .dmi_wr_i    ( dmi_wr    ),
        .dmi_addr_i  ( dmi_addr  ),
        .dmi_wdata_i ( dmi_wdata ),
        .dmi_rdata_o ( dmi_rdata ),
        .debug_req_o ( debug_req )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Handshake rules over the whole run
    ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_resp.ack && wb_resp.err)) else abort_run("ack and err were high together");
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_resp.ack |=> !wb_resp.ack) else abort_run("ack was high for more than one cycle");
    err_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_resp.err |=> !wb_resp.err) else abort_run("err was high for more than one cycle");
    resp_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_req.stb) |=> (wb_resp.ack || wb_resp.err))
        else abort_run("No ack or err one cycle after stb");

    initial begin
        logic [`BUS_DATA_WIDTH-1:0] rdata;
        logic [`BUS_DATA_WIDTH-1:0] wdata;
        logic [`BUS_SEL_WIDTH-1:0]  sel;
        logic [IDX_BITS-1:0]        idx;
        logic [`DMI_DATA_WIDTH-1:0] dvalue;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        wb_req    = '0;
        dmi_req   = 1'b0;
        dmi_wr    = 1'b0;
        dmi_addr  = '0;
        dmi_wdata = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        expect_equal("wb_resp.ack", 64'h0, 64'(wb_resp.ack));
        expect_equal("wb_resp.err", 64'h0, 64'(wb_resp.err));
        expect_equal("debug_req_o", 64'h0, 64'(debug_req));
        expect_equal("dmi_rdata_o", 64'h0, 64'(dmi_rdata));

        // Full writes to tested words that alternate between ROM and DMEM
        for (int i = 0; i < NUM_WORDS; i++) begin
            word_idx[i] = IDX_BITS'($urandom_range(0, `SRAM_WORDS/2 - 1)
                                    + (i % 2) * (`SRAM_WORDS/2));
            wdata       = {$urandom(), $urandom()};
            bus_transfer(1'b1, word_addr(word_idx[i]), '1, wdata, 1'b0, rdata);
            model_mem[word_idx[i]] = wdata;
        end
        for (int i = 0; i < NUM_PARTIAL; i++) begin
            idx   = word_idx[$urandom_range(0, NUM_WORDS - 1)];
            wdata = {$urandom(), $urandom()};
            sel   = 8'($urandom());
            bus_transfer(1'b1, word_addr(idx), sel, wdata, 1'b0, rdata);
            model_mem[idx] = merge_bytes(model_mem[idx], wdata, sel);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            bus_transfer(1'b0, word_addr(word_idx[i]), '1, '0, 1'b0, rdata);
            expect_equal("wb_resp.dat", model_mem[word_idx[i]], rdata);
        end

        // Unmapped accesses where the second would alias word_idx[0] if decoded
        bus_transfer(1'b1, 32'h2000_0000, '1, {$urandom(), $urandom()}, 1'b1, rdata);
        bus_transfer(1'b1, `DMEM_BASE + `DMEM_LENGTH + word_addr(word_idx[0]), '1,
                     ~model_mem[word_idx[0]], 1'b1, rdata);
        bus_transfer(1'b0, `DEBUG_BASE + `DEBUG_LENGTH, '1, '0, 1'b1, rdata);
        bus_transfer(1'b0, word_addr(word_idx[0]), '1, '0, 1'b0, rdata);
        expect_equal("wb_resp.dat", model_mem[word_idx[0]], rdata);

        // data0 shared between DMI and bus
        dvalue = $urandom();
        dmi_write(DM_DATA0, dvalue);
        bus_transfer(1'b0, `DEBUG_BASE, '1, '0, 1'b0, rdata);
        expect_equal("wb_resp.dat", {32'h0, dvalue}, rdata);
        wdata = {$urandom(), $urandom()};
        bus_transfer(1'b1, `DEBUG_BASE, '1, wdata, 1'b0, rdata);
        dmi_read_check(DM_DATA0, wdata[31:0]);
        repeat (3) @(negedge clk);
        expect_equal("dmi_rdata_o", 64'(wdata[31:0]), 64'(dmi_rdata));

        // Master holds stb after the response and no target may answer twice
        held_stb_read(word_addr(word_idx[1]), 1'b0, 3, rdata);
        expect_equal("wb_resp.dat", model_mem[word_idx[1]], rdata);
        held_stb_read(`DEBUG_BASE, 1'b0, 3, rdata);
        expect_equal("wb_resp.dat", {32'h0, wdata[31:0]}, rdata);
        held_stb_read(32'h2000_0000, 1'b1, 3, rdata);

        // Halt request
        dmi_write(DM_CONTROL, 32'h8000_0000);
        expect_equal("debug_req_o", 64'h1, 64'(debug_req));
        bus_transfer(1'b0, `DEBUG_BASE + 32'h8, '1, '0, 1'b0, rdata);
        expect_equal("wb_resp.dat", 64'h100, rdata);
        dmi_read_check(DM_STATUS, 32'h100);
        dmi_read_check(DM_CONTROL, 32'h8000_0000);
        dmi_write(DM_CONTROL, 32'h0);
        expect_equal("debug_req_o", 64'h0, 64'(debug_req));
        dmi_read_check(DM_STATUS, 32'h0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/soc_harness.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory and debug harness top level.
// An external Wishbone master reaches the SRAM and the debug
// registers. The DMI strobe must be high for one cycle only,
// a held strobe repeats the access every cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "harness_macros.svh"

module soc_harness import bus_pkg::*, debug_pkg::*; (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire wb_req_t                      wb_req_i,
    output wb_resp_t                          wb_resp_o,
    input  wire logic                         dmi_req_i,     // One-cycle strobe
    input  wire logic                         dmi_wr_i,
    input  wire logic [`DMI_ADDR_WIDTH-1:0]   dmi_addr_i,
    input  wire logic [`DMI_DATA_WIDTH-1:0]   dmi_wdata_i,
    output logic [`DMI_DATA_WIDTH-1:0]        dmi_rdata_o,
    output logic                              debug_req_o
);

    wb_req_t  mem_req;
    wb_resp_t mem_resp;
    wb_req_t  dbg_req;
    wb_resp_t dbg_resp;
    dmi_req_t dmi_req;

    // Strobe and write flag folded into one operation
    assign dmi_req.op   = dmi_req_i ? (dmi_wr_i ? DMI_WRITE : DMI_READ) : DMI_NOP;
    assign dmi_req.addr = dmi_addr_i;
    assign dmi_req.data = dmi_wdata_i;

    bus_decoder i_bus_decoder (
        .clk_i      ( clk_i     ),
        .rst_n_i    ( rst_n_i   ),
        .wb_req_i   ( wb_req_i  ),
        .mem_resp_i ( mem_resp  ),
        .dbg_resp_i ( dbg_resp  ),
        .wb_resp_o  ( wb_resp_o ),
        .mem_req_o  ( mem_req   ),
        .dbg_req_o  ( dbg_req   )
    );

    byte_sram i_byte_sram (
        .clk_i     ( clk_i    ),
        .rst_n_i   ( rst_n_i  ),
        .wb_req_i  ( mem_req  ),
        .wb_resp_o ( mem_resp )
    );

    debug_regs i_debug_regs (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .wb_req_i    ( dbg_req     ),
        .dmi_req_i   ( dmi_req     ),
        .wb_resp_o   ( dbg_resp    ),
        .dmi_rdata_o ( dmi_rdata_o ),
        .debug_req_o ( debug_req_o )
    );

endmodule

`default_nettype wire

/* rtl/debug_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug register block with a DMI port and a Wishbone port.
// Bus map: offset 0 data0, offset 8 status, rest reads zero.
// A DMI write to data0 wins over a bus write in the same cycle.
// DMI read data is captured one cycle after the request and
// held until the next DMI read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "harness_macros.svh"

module debug_regs import bus_pkg::*, debug_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire wb_req_t                    wb_req_i,
    input  wire dmi_req_t                   dmi_req_i,
    output wb_resp_t                        wb_resp_o,
    output logic [`DMI_DATA_WIDTH-1:0]      dmi_rdata_o,
    output logic                            debug_req_o
);

    localparam int unsigned HALT_CTRL_BIT = 31;
    localparam int unsigned HALT_STAT_BIT = 8;
    localparam logic [`BUS_ADDR_WIDTH-1:0] OFFS_DATA0  = 'h0;
    localparam logic [`BUS_ADDR_WIDTH-1:0] OFFS_STATUS = 'h8;

    logic [`DMI_DATA_WIDTH-1:0] data0_q;
    logic                       halt_q;
    logic [`DMI_DATA_WIDTH-1:0] status_w;
    logic [`DMI_DATA_WIDTH-1:0] dmi_rd_word;
    logic [`DMI_DATA_WIDTH-1:0] dmi_rdata_q;
    logic [`BUS_ADDR_WIDTH-1:0] bus_off;
    logic [`BUS_DATA_WIDTH-1:0] bus_rd_word;
    logic [`BUS_DATA_WIDTH-1:0] bus_rdata_q;
    logic                       req_valid;
    logic                       access;
    logic                       bus_wr_data0;
    logic                       dmi_wr;
    logic                       ack_q;
    logic                       served_q;

    always_comb begin
        status_w                = '0;
        status_w[HALT_STAT_BIT] = halt_q;
    end

    assign bus_off      = wb_req_i.adr - `DEBUG_BASE;
    assign req_valid    = wb_req_i.cyc && wb_req_i.stb;
    assign access       = req_valid && !served_q;
    assign bus_wr_data0 = access && wb_req_i.we && (bus_off == OFFS_DATA0);
    assign dmi_wr       = (dmi_req_i.op == DMI_WRITE);

    // DMI read mux
    always_comb begin
        case (dmi_req_i.addr)
            DM_DATA0:   dmi_rd_word = data0_q;
            DM_CONTROL: dmi_rd_word = {halt_q, {(`DMI_DATA_WIDTH-1){1'b0}}};
            DM_STATUS:  dmi_rd_word = status_w;
            default:    dmi_rd_word = '0;   // Unknown register
        endcase
    end

    // Bus read mux, 32-bit registers zero-extended
    always_comb begin
        if (bus_off == OFFS_DATA0) begin
            bus_rd_word = {{(`BUS_DATA_WIDTH-`DMI_DATA_WIDTH){1'b0}}, data0_q};
        end else if (bus_off == OFFS_STATUS) begin
            bus_rd_word = {{(`BUS_DATA_WIDTH-`DMI_DATA_WIDTH){1'b0}}, status_w};
        end else begin
            bus_rd_word = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data0_q     <= '0;
            halt_q      <= 1'b0;
            dmi_rdata_q <= '0;
        end else begin
            if (dmi_wr && (dmi_req_i.addr == DM_DATA0)) begin
                data0_q <= dmi_req_i.data;
            end else if (bus_wr_data0) begin
                for (int b = 0; b < `DMI_DATA_WIDTH/8; b++) begin
                    if (wb_req_i.sel[b]) begin
                        data0_q[b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
                    end
                end
            end
            if (dmi_wr && (dmi_req_i.addr == DM_CONTROL)) begin
                halt_q <= dmi_req_i.data[HALT_CTRL_BIT];
            end
            if (dmi_req_i.op == DMI_READ) begin
                dmi_rdata_q <= dmi_rd_word;   // Held until next read
            end
        end
    end

    // Bus handshake, one ack per stb
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q    <= access;
            served_q <= req_valid ? (served_q || access) : 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && !wb_req_i.we) begin
            bus_rdata_q <= bus_rd_word;
        end
    end

    always_comb begin
        wb_resp_o     = '0;
        wb_resp_o.ack = ack_q;
        wb_resp_o.dat = bus_rdata_q;
    end

    assign dmi_rdata_o = dmi_rdata_q;
    assign debug_req_o = halt_q;

endmodule

`default_nettype wire

/* rtl/byte_sram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone slave SRAM, 64-bit words with byte enables.
// ack and read data come one cycle after stb. A held stb is
// acknowledged once, the next transfer needs stb low first.
// Content is undefined after reset. Address bits above the
// SRAM size are ignored, the decoder keeps them in range.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "harness_macros.svh"

module byte_sram import bus_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,
    input  wire wb_req_t wb_req_i,
    output wb_resp_t     wb_resp_o
);

    localparam int unsigned OFFS_BITS = $clog2(`BUS_SEL_WIDTH);
    localparam int unsigned IDX_BITS  = $clog2(`SRAM_WORDS);

    logic [`BUS_DATA_WIDTH-1:0] mem [`SRAM_WORDS];
    logic [`BUS_ADDR_WIDTH-1:0] mem_off;
    logic [IDX_BITS-1:0]        word_idx;
    logic [`BUS_DATA_WIDTH-1:0] rdata_q;
    logic                       req_valid;
    logic                       access;
    logic                       ack_q;
    logic                       served_q;

    assign mem_off  = wb_req_i.adr - `ROM_BASE;
    assign word_idx = mem_off[IDX_BITS+OFFS_BITS-1:OFFS_BITS]; // Drop byte offset

    assign req_valid = wb_req_i.cyc && wb_req_i.stb;
    assign access    = req_valid && !served_q;  // First cycle of a transfer only

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (wb_req_i.we) begin
                for (int b = 0; b < `BUS_SEL_WIDTH; b++) begin
                    if (wb_req_i.sel[b]) begin
                        mem[word_idx][b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[word_idx];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q    <= access;
            served_q <= req_valid ? (served_q || access) : 1'b0;
        end
    end

    always_comb begin
        wb_resp_o     = '0;
        wb_resp_o.ack = ack_q;
        wb_resp_o.dat = rdata_q;
    end

endmodule

`default_nettype wire

/* rtl/bus_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder for one Wishbone master and two slaves.
// Routing is combinational, so the master sees the latency of
// the selected slave. Unmapped addresses get a registered err
// one cycle after stb. The master must hold the address until
// it sees ack or err.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

`include "harness_macros.svh"

module bus_decoder import bus_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire wb_req_t  wb_req_i,
    input  wire wb_resp_t mem_resp_i,
    input  wire wb_resp_t dbg_resp_i,
    output wb_resp_t      wb_resp_o,
    output wb_req_t       mem_req_o,
    output wb_req_t       dbg_req_o
);

    localparam logic [`BUS_ADDR_WIDTH-1:0] MEM_SPAN = `DMEM_BASE + `DMEM_LENGTH - `ROM_BASE;

    logic [`BUS_ADDR_WIDTH-1:0] mem_off;
    logic [`BUS_ADDR_WIDTH-1:0] dbg_off;
    target_e                    target;
    logic                       req_valid;
    logic                       err_d;
    logic                       err_q;
    logic                       served_q;   // Err already given for this stb

    // Window offsets, wrap-around puts low addresses out of range
    assign mem_off = wb_req_i.adr - `ROM_BASE;
    assign dbg_off = wb_req_i.adr - `DEBUG_BASE;

    always_comb begin
        if (mem_off < MEM_SPAN) begin
            target = TARGET_MEM;
        end else if (dbg_off < `DEBUG_LENGTH) begin
            target = TARGET_DEBUG;
        end else begin
            target = TARGET_NONE;
        end
    end

    // Only the selected slave sees stb
    always_comb begin
        mem_req_o     = wb_req_i;
        dbg_req_o     = wb_req_i;
        mem_req_o.stb = wb_req_i.stb && (target == TARGET_MEM);
        dbg_req_o.stb = wb_req_i.stb && (target == TARGET_DEBUG);
    end

    assign req_valid = wb_req_i.cyc && wb_req_i.stb;
    assign err_d     = req_valid && (target == TARGET_NONE) && !served_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            err_q    <= err_d;
            served_q <= req_valid ? (served_q || err_d) : 1'b0; // Cleared once stb drops
        end
    end

    // Response path follows the address still held by the master
    always_comb begin
        case (target)
            TARGET_MEM:   wb_resp_o = mem_resp_i;
            TARGET_DEBUG: wb_resp_o = dbg_resp_i;
            default: begin
                wb_resp_o     = '0;
                wb_resp_o.err = err_q;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/debug_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug module interface types.
// Only a small subset of the debug register map is present.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "harness_macros.svh"

package debug_pkg;

    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    // Valid for one cycle, op is DMI_NOP when idle
    typedef struct packed {
        dmi_op_e                      op;
        logic [`DMI_ADDR_WIDTH-1:0]   addr;
        logic [`DMI_DATA_WIDTH-1:0]   data;
    } dmi_req_t;

    // Implemented DMI register addresses
    typedef enum logic [`DMI_ADDR_WIDTH-1:0] {
        DM_DATA0   = 7'h04,
        DM_CONTROL = 7'h10,   // Bit 31 halt request
        DM_STATUS  = 7'h11    // Read-only, bit 8 mirrors halt request
    } dm_reg_e;

endpackage

`default_nettype wire

/* rtl/bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic types shared by master, decoder and slaves.
// One outstanding transfer at a time, no pipelined mode.
// A response carries ack or err, never both.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "harness_macros.svh"

package bus_pkg;

    // One master request, held stable until ack or err
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`BUS_ADDR_WIDTH-1:0]   adr;
        logic [`BUS_SEL_WIDTH-1:0]    sel;   // Byte enables
        logic [`BUS_DATA_WIDTH-1:0]   dat;   // Write data
    } wb_req_t;

    // Slave response, valid for exactly one cycle
    typedef struct packed {
        logic                         ack;
        logic                         err;
        logic [`BUS_DATA_WIDTH-1:0]   dat;   // Read data
    } wb_resp_t;

    // Decoded destination of a transfer
    typedef enum logic [1:0] {
        TARGET_MEM   = 2'd0,
        TARGET_DEBUG = 2'd1,
        TARGET_NONE  = 2'd2
    } target_e;

endpackage

`default_nettype wire

/* rtl/harness_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map and widths of the memory and debug harness.
// The SRAM spans the ROM and data-memory windows back to back,
// so SRAM_WORDS times the bus width in bytes must match both.
// Addresses are byte addresses on a 64-bit data bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

// Wishbone bus geometry
`define BUS_ADDR_WIDTH 32
`define BUS_DATA_WIDTH 64
`define BUS_SEL_WIDTH  8

// Memory windows, both backed by one SRAM
`define ROM_BASE    32'h0000_0000
`define ROM_LENGTH  32'h0000_4000
`define DMEM_BASE   32'h0000_4000
`define DMEM_LENGTH 32'h0000_4000

`define DEBUG_BASE   32'h1200_0000
`define DEBUG_LENGTH 32'h0000_1000

`define SRAM_WORDS 4096 // 64-bit words

// Debug module interface
`define DMI_ADDR_WIDTH 7
`define DMI_DATA_WIDTH 32

`endif
